// ==== alloc_ctrl.sv ====
module alloc_ctrl #(
  parameter int unsigned ADDR_W = heap_pkg::ADDR_W_DEF
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [ADDR_W-1:0]       free_list_ptr_i,
  input  logic                    req_valid_i,
  input  logic [ADDR_W-1:0]       req_size_i,
  input  heap_pkg::fit_strategy_e req_strategy_i,
  output logic                    req_ready_o,
  output logic                    result_valid_o,
  output logic [ADDR_W-1:0]       result_addr_o,
  input  logic                    result_ready_i,
  header_bus_if.ctrl              bus,
  output logic                    search_start_o,
  output logic                    hdr_valid_o,
  output heap_pkg::header_t       hdr_o,
  output heap_pkg::fit_strategy_e strategy_o,
  output logic [ADDR_W-1:0]       size_o,
  input  logic                    search_done_i,
  input  logic                    found_i,
  input  heap_pkg::header_t       alloc_hdr_i,
  input  heap_pkg::header_t       create_hdr_i,
  input  heap_pkg::header_t       link_hdr_i,
  input  logic                    split_i
);

  // header write sequence
  typedef enum logic [1:0] {
    WR_ALLOC,
    WR_CREATE,
    WR_LINK
  } wr_step_e;

  heap_pkg::alloc_state_e  state_q, state_d;
  wr_step_e                wr_step_q, wr_step_d;
  heap_pkg::fit_strategy_e strategy_q;
  logic [ADDR_W-1:0]       size_q;
  logic [ADDR_W-1:0]       next_addr_q;  // header to load next
  logic [ADDR_W-1:0]       result_addr_q;
  heap_pkg::header_t       load_hdr;
  logic                    accept;

  assign req_ready_o    = (state_q == heap_pkg::ST_IDLE);
  assign accept         = req_valid_i && req_ready_o;
  assign search_start_o = accept;
  assign strategy_o     = strategy_q;
  assign size_o         = size_q;
  assign hdr_o          = bus.rsp_header;
  assign result_valid_o = (state_q == heap_pkg::ST_RESULT);
  assign result_addr_o  = result_addr_q;

  always_comb begin
    load_hdr      = '0;
    load_hdr.addr = next_addr_q;
  end

  always_comb begin
    state_d        = state_q;
    wr_step_d      = wr_step_q;
    hdr_valid_o    = 1'b0;
    bus.req_valid  = 1'b0;
    bus.req_op     = heap_pkg::HDR_LOAD;
    bus.req_header = load_hdr;

    unique case (state_q)
      heap_pkg::ST_IDLE: begin
        if (accept) state_d = heap_pkg::ST_LOAD;
      end
      heap_pkg::ST_LOAD: begin
        bus.req_valid = bus.req_ready;
        if (bus.req_ready) state_d = heap_pkg::ST_WAIT_LOAD;
      end
      heap_pkg::ST_WAIT_LOAD: begin
        if (bus.rsp_valid) begin
          hdr_valid_o = 1'b1;  // feed fit search
          state_d     = heap_pkg::ST_SEARCH;
        end
      end
      heap_pkg::ST_SEARCH: begin
        if (!search_done_i) begin
          state_d = heap_pkg::ST_LOAD;
        end else if (found_i) begin
          wr_step_d = WR_ALLOC;
          state_d   = heap_pkg::ST_WRITE;
        end else begin
          state_d = heap_pkg::ST_RESULT;  // list ended, nothing written
        end
      end
      heap_pkg::ST_WRITE: begin
        bus.req_valid = bus.req_ready;
        unique case (wr_step_q)
          WR_ALLOC: begin
            bus.req_op     = heap_pkg::HDR_WRITE_SIZE_NEXT;
            bus.req_header = alloc_hdr_i;
          end
          WR_CREATE: begin
            bus.req_op     = heap_pkg::HDR_WRITE_SIZE_NEXT;
            bus.req_header = create_hdr_i;
          end
          default: begin
            bus.req_op     = heap_pkg::HDR_WRITE_NEXT;
            bus.req_header = link_hdr_i;
          end
        endcase
        if (bus.req_ready) state_d = heap_pkg::ST_WAIT_WRITE;
      end
      heap_pkg::ST_WAIT_WRITE: begin
        if (bus.rsp_valid) begin
          state_d = heap_pkg::ST_WRITE;
          unique case (wr_step_q)
            WR_ALLOC:  wr_step_d = split_i ? WR_CREATE : WR_LINK;
            WR_CREATE: wr_step_d = WR_LINK;
            default:   state_d = heap_pkg::ST_RESULT;
          endcase
        end
      end
      heap_pkg::ST_RESULT: begin
        if (result_ready_i) state_d = heap_pkg::ST_IDLE;
      end
      default: state_d = heap_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= heap_pkg::ST_IDLE;
      wr_step_q <= WR_ALLOC;
    end else begin
      state_q   <= state_d;
      wr_step_q <= wr_step_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      size_q      <= req_size_i;
      strategy_q  <= req_strategy_i;
      next_addr_q <= free_list_ptr_i;  // walk starts at the sentinel
    end else if (state_q == heap_pkg::ST_WAIT_LOAD && bus.rsp_valid) begin
      next_addr_q <= bus.rsp_header.next_addr;
    end
    if (state_q == heap_pkg::ST_SEARCH && search_done_i) begin
      result_addr_q <= found_i ? alloc_hdr_i.addr : '0;
    end
  end

endmodule

// ==== alloc_vectors.txt ====
# H addr size next : initial header, first H is the sentinel
# R strategy(0 first,1 best) size expected_addr : request in order
# C addr size next : header contents after all requests
H 00000100 00000000 00000200
H 00000200 00000040 00000300
H 00000300 00000010 00000400
H 00000400 00000020 00000500
H 00000500 00000014 00000000
R 0 00000010 00000200
R 1 00000010 00000300
R 1 00000010 00000500
R 0 00000100 00000000
R 0 0000001c 0000021c
R 1 0000001c 00000400
R 0 0000000c 00000244
C 00000100 00000000 0000025c
C 00000200 00000010 00000000
C 00000300 00000010 00000000
C 00000400 00000020 00000000
C 00000500 00000014 00000000
C 0000021c 0000001c 00000000
C 00000244 0000000c 00000000
C 0000025c 00000008 00000000

// ==== fit_search.sv ====
module fit_search #(
  parameter int unsigned ADDR_W         = heap_pkg::ADDR_W_DEF,
  parameter int unsigned HDR_SIZE       = heap_pkg::HDR_SIZE_DEF,
  parameter int unsigned MIN_ALLOC_SIZE = heap_pkg::MIN_ALLOC_DEF
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  logic                    hdr_valid_i,
  input  heap_pkg::header_t       hdr_i,
  input  heap_pkg::fit_strategy_e strategy_i,
  input  logic [ADDR_W-1:0]       size_i,
  output logic                    done_o,
  output logic                    found_o,
  output heap_pkg::header_t       alloc_hdr_o,
  output heap_pkg::header_t       create_hdr_o,
  output heap_pkg::header_t       link_hdr_o,
  output logic                    split_o
);

  logic              first_q;  // next header is the sentinel
  logic              found_q;
  logic              done_q;
  heap_pkg::header_t prev_q;
  heap_pkg::header_t fit_q;
  heap_pkg::header_t fit_prev_q;
  logic [ADDR_W-1:0] diff_q;

  logic              fits;
  logic              take;
  logic              last;
  logic [ADDR_W-1:0] diff;
  logic [ADDR_W-1:0] remain;

  assign fits = !first_q && (hdr_i.size >= size_i);
  assign diff = hdr_i.size - size_i;
  // strict compare keeps the earlier block on a tie
  assign take = fits && (!found_q || diff < diff_q);
  assign last = (hdr_i.next_addr == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      first_q <= 1'b1;
      found_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        first_q <= 1'b1;
        found_q <= 1'b0;
      end else if (hdr_valid_i) begin
        first_q <= 1'b0;
        if (take) begin
          found_q <= 1'b1;
        end
        done_q <= last || (fits && strategy_i == heap_pkg::FIRST_FIT);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hdr_valid_i) begin
      prev_q <= hdr_i;
      if (take) begin
        fit_q      <= hdr_i;
        fit_prev_q <= prev_q;
        diff_q     <= diff;
      end
    end
  end

  assign done_o  = done_q;
  assign found_o = found_q;

  assign remain  = fit_q.size - size_i;
  assign split_o = (remain >= ADDR_W'(MIN_ALLOC_SIZE));

  always_comb begin
    alloc_hdr_o.addr      = fit_q.addr;
    alloc_hdr_o.size      = split_o ? size_i : fit_q.size;  // whole block if no split
    alloc_hdr_o.next_addr = '0;

    create_hdr_o.addr      = fit_q.addr + ADDR_W'(HDR_SIZE) + size_i;
    create_hdr_o.size      = remain;
    create_hdr_o.next_addr = fit_q.next_addr;

    link_hdr_o           = fit_prev_q;
    link_hdr_o.next_addr = split_o ? create_hdr_o.addr : fit_q.next_addr;
  end

endmodule

// ==== header_bus_if.sv ====
interface header_bus_if;

  // request, controller to memory port
  logic              req_valid;
  heap_pkg::hdr_op_e req_op;
  heap_pkg::header_t req_header;
  logic              req_ready;  // port is empty

  // response, single-cycle pulse
  logic              rsp_valid;
  heap_pkg::header_t rsp_header;

  modport ctrl (
    output req_valid,
    output req_op,
    output req_header,
    input  req_ready,
    input  rsp_valid,
    input  rsp_header
  );

  modport port (
    input  req_valid,
    input  req_op,
    input  req_header,
    output req_ready,
    output rsp_valid,
    output rsp_header
  );

endinterface

// ==== header_port.sv ====
module header_port (
  input  logic              clk_i,
  input  logic              rst_ni,
  header_bus_if.port        bus,
  output logic              mem_req_valid_o,
  output heap_pkg::hdr_op_e mem_req_op_o,
  output heap_pkg::header_t mem_req_header_o,
  input  logic              mem_ready_i,
  input  logic              mem_rsp_valid_i,
  input  heap_pkg::header_t mem_rsp_header_i
);

  logic              pend_q;
  logic              rsp_valid_q;
  heap_pkg::hdr_op_e op_q;
  heap_pkg::header_t hdr_q;
  heap_pkg::header_t rsp_hdr_q;
  logic              accept;

  assign accept = bus.req_valid && !pend_q;

  assign bus.req_ready      = !pend_q;
  assign mem_req_valid_o    = pend_q;
  assign mem_req_op_o       = op_q;
  assign mem_req_header_o   = hdr_q;
  assign bus.rsp_valid      = rsp_valid_q;
  assign bus.rsp_header     = rsp_hdr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pend_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        pend_q <= 1'b1;
      end else if (mem_ready_i) begin
        pend_q <= 1'b0;  // taken by memory
      end
      // loads complete on data, writes on acceptance
      rsp_valid_q <= mem_rsp_valid_i ||
                     (pend_q && mem_ready_i && op_q != heap_pkg::HDR_LOAD);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= bus.req_op;
      hdr_q <= bus.req_header;
    end
    if (mem_rsp_valid_i) begin
      rsp_hdr_q <= mem_rsp_header_i;
    end
  end

endmodule

// ==== heap_alloc_assert.sv ====
module heap_alloc_assert (
  input logic                   clk_i,
  input logic                   rst_ni,
  input heap_pkg::alloc_state_e state_i,
  input logic                   mem_req_valid_i,
  input heap_pkg::hdr_op_e      mem_req_op_i,
  input heap_pkg::header_t      mem_req_header_i,
  input logic                   mem_ready_i,
  input logic                   result_valid_i,
  input logic [31:0]            result_addr_i,
  input logic                   result_ready_i
);

  // memory request held until taken
  mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_i && !mem_ready_i |=>
      mem_req_valid_i && $stable(mem_req_op_i) && $stable(mem_req_header_i))
    else $error("memory request changed before mem_ready_i");

  // result held under back-pressure
  result_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_i && !result_ready_i |=>
      result_valid_i && $stable(result_addr_i))
    else $error("result changed before result_ready_i");

  idle_no_mem_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == heap_pkg::ST_IDLE |-> !mem_req_valid_i)
    else $error("memory request valid while controller idle");

endmodule

// ==== heap_alloc_top.sv ====
module heap_alloc_top #(
  parameter int unsigned ADDR_W         = heap_pkg::ADDR_W_DEF,
  parameter int unsigned HDR_SIZE       = heap_pkg::HDR_SIZE_DEF,
  parameter int unsigned MIN_ALLOC_SIZE = heap_pkg::MIN_ALLOC_DEF
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [ADDR_W-1:0]       free_list_ptr_i,
  input  logic                    req_valid_i,
  input  logic [ADDR_W-1:0]       req_size_i,
  input  heap_pkg::fit_strategy_e req_strategy_i,
  output logic                    req_ready_o,
  output logic                    mem_req_valid_o,
  output heap_pkg::hdr_op_e       mem_req_op_o,
  output heap_pkg::header_t       mem_req_header_o,
  input  logic                    mem_ready_i,
  input  logic                    mem_rsp_valid_i,
  input  heap_pkg::header_t       mem_rsp_header_i,
  output logic                    result_valid_o,
  output logic [ADDR_W-1:0]       result_addr_o,
  input  logic                    result_ready_i
);

  // header fields are fixed by the package width
  if (ADDR_W != heap_pkg::ADDR_W_DEF) begin : g_width_check
    $error("ADDR_W must equal heap_pkg::ADDR_W_DEF");
  end

  logic                    search_start;
  logic                    hdr_valid;
  heap_pkg::header_t       hdr;
  heap_pkg::fit_strategy_e strategy;
  logic [ADDR_W-1:0]       size;
  logic                    search_done;
  logic                    found;
  heap_pkg::header_t       alloc_hdr;
  heap_pkg::header_t       create_hdr;
  heap_pkg::header_t       link_hdr;
  logic                    split;

  header_bus_if hdr_bus ();

  alloc_ctrl #(
    .ADDR_W (ADDR_W)
  ) i_alloc_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .free_list_ptr_i (free_list_ptr_i),
    .req_valid_i     (req_valid_i),
    .req_size_i      (req_size_i),
    .req_strategy_i  (req_strategy_i),
    .req_ready_o     (req_ready_o),
    .result_valid_o  (result_valid_o),
    .result_addr_o   (result_addr_o),
    .result_ready_i  (result_ready_i),
    .bus             (hdr_bus.ctrl),
    .search_start_o  (search_start),
    .hdr_valid_o     (hdr_valid),
    .hdr_o           (hdr),
    .strategy_o      (strategy),
    .size_o          (size),
    .search_done_i   (search_done),
    .found_i         (found),
    .alloc_hdr_i     (alloc_hdr),
    .create_hdr_i    (create_hdr),
    .link_hdr_i      (link_hdr),
    .split_i         (split)
  );

  fit_search #(
    .ADDR_W         (ADDR_W),
    .HDR_SIZE       (HDR_SIZE),
    .MIN_ALLOC_SIZE (MIN_ALLOC_SIZE)
  ) i_fit_search (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (search_start),
    .hdr_valid_i  (hdr_valid),
    .hdr_i        (hdr),
    .strategy_i   (strategy),
    .size_i       (size),
    .done_o       (search_done),
    .found_o      (found),
    .alloc_hdr_o  (alloc_hdr),
    .create_hdr_o (create_hdr),
    .link_hdr_o   (link_hdr),
    .split_o      (split)
  );

  header_port i_header_port (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus              (hdr_bus.port),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_op_o     (mem_req_op_o),
    .mem_req_header_o (mem_req_header_o),
    .mem_ready_i      (mem_ready_i),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .mem_rsp_header_i (mem_rsp_header_i)
  );

endmodule

// ==== heap_pkg.sv ====
package heap_pkg;

  // defaults for the top-level parameters
  localparam int unsigned ADDR_W_DEF    = 32;
  localparam int unsigned HDR_SIZE_DEF  = 12;  // bytes per header
  localparam int unsigned MIN_ALLOC_DEF = 8;

  // block header as stored in memory
  typedef struct packed {
    logic [ADDR_W_DEF-1:0] addr;
    logic [ADDR_W_DEF-1:0] size;
    logic [ADDR_W_DEF-1:0] next_addr;
  } header_t;

  // header memory operation
  typedef enum logic [1:0] {
    HDR_LOAD,
    HDR_WRITE_SIZE_NEXT,
    HDR_WRITE_NEXT
  } hdr_op_e;

  typedef enum logic {
    FIRST_FIT,
    BEST_FIT
  } fit_strategy_e;

  // allocation controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,        // issue header load
    ST_WAIT_LOAD,
    ST_SEARCH,      // fit search result
    ST_WRITE,       // issue header write
    ST_WAIT_WRITE,
    ST_RESULT
  } alloc_state_e;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the heap allocator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_heap_alloc -o tb_heap_alloc \
  && ./obj_dir/tb_heap_alloc 2>&1 | tee sim.log \
  || { echo "build or run error"; exit 1; }

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation passed"
exit 0

// ==== sim.f ====
heap_pkg.sv
header_bus_if.sv
header_port.sv
fit_search.sv
alloc_ctrl.sv
heap_alloc_top.sv
heap_alloc_assert.sv
tb_heap_alloc.sv

// ==== tb_heap_alloc.sv ====
module tb_heap_alloc;

  localparam int TIMEOUT = 2000;

  logic                    clk_i;
  logic                    rst_ni;
  logic [31:0]             free_list_ptr_i;
  logic                    req_valid_i;
  logic [31:0]             req_size_i;
  heap_pkg::fit_strategy_e req_strategy_i;
  logic                    req_ready_o;
  logic                    mem_req_valid_o;
  heap_pkg::hdr_op_e       mem_req_op_o;
  heap_pkg::header_t       mem_req_header_o;
  logic                    mem_ready_i;
  logic                    mem_rsp_valid_i;
  heap_pkg::header_t       mem_rsp_header_i;
  logic                    result_valid_o;
  logic [31:0]             result_addr_o;
  logic                    result_ready_i;

  // header memory model, keyed by header address
  logic [31:0] size_mem [logic [31:0]];
  logic [31:0] next_mem [logic [31:0]];

  logic [31:0] r_best[$], r_size[$], r_exp[$];
  logic [31:0] c_addr[$], c_size[$], c_next[$];

  logic [31:0]       mem_seed = 32'd78;
  logic [31:0]       res_seed;
  int                write_count = 0;
  int                mismatches = 0;
  int                other_errors = 0;
  logic              hs_pend = 1'b0;
  heap_pkg::hdr_op_e hs_op;
  heap_pkg::header_t hs_hdr;
  logic              loading = 1'b0;
  int                load_delay;
  heap_pkg::header_t load_hdr;

  heap_alloc_top i_heap_alloc_top (.*);

  bind heap_alloc_top heap_alloc_assert i_handshake_assert (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .state_i          (i_alloc_ctrl.state_q),
    .mem_req_valid_i  (mem_req_valid_o),
    .mem_req_op_i     (mem_req_op_o),
    .mem_req_header_i (mem_req_header_o),
    .mem_ready_i      (mem_ready_i),
    .result_valid_i   (result_valid_o),
    .result_addr_i    (result_addr_o),
    .result_ready_i   (result_ready_i)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $finish;
  endtask

  // memory model, handshake seen before the edge is served after it
  always begin
    @(posedge clk_i);
    #1;
    mem_rsp_valid_i = 1'b0;
    if (hs_pend) begin
      if (hs_op == heap_pkg::HDR_LOAD) begin
        mem_seed   = lcg_next(mem_seed);
        load_delay = int'(mem_seed[17:16]);  // 0 to 3 cycles
        load_hdr.addr      = hs_hdr.addr;
        load_hdr.size      = size_mem.exists(hs_hdr.addr) ? size_mem[hs_hdr.addr] : '0;
        load_hdr.next_addr = next_mem.exists(hs_hdr.addr) ? next_mem[hs_hdr.addr] : '0;
        loading = 1'b1;
      end else begin
        if (hs_op == heap_pkg::HDR_WRITE_SIZE_NEXT) size_mem[hs_hdr.addr] = hs_hdr.size;
        next_mem[hs_hdr.addr] = hs_hdr.next_addr;
        write_count++;
      end
    end
    if (loading) begin
      if (load_delay == 0) begin
        mem_rsp_valid_i  = 1'b1;
        mem_rsp_header_i = load_hdr;
        loading          = 1'b0;
      end else begin
        load_delay--;
      end
    end
    mem_seed    = lcg_next(mem_seed);
    mem_ready_i = (mem_seed[19:18] != 2'b00);
    hs_pend     = mem_req_valid_o && mem_ready_i;
    hs_op       = mem_req_op_o;
    hs_hdr      = mem_req_header_o;
  end

  initial begin
    int          fd;
    int          wait_cnt;
    int          writes_before;
    logic        got;
    logic        first_h;
    string       line;
    logic [31:0] a, s, n;
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    free_list_ptr_i  = '0;
    req_valid_i      = 1'b0;
    req_size_i       = '0;
    req_strategy_i   = heap_pkg::FIRST_FIT;
    mem_ready_i      = 1'b0;
    mem_rsp_valid_i  = 1'b0;
    mem_rsp_header_i = '0;
    result_ready_i   = 1'b0;
    res_seed         = lcg_next(32'd78);
    first_h          = 1'b1;

    fd = $fopen("alloc_vectors.txt", "r");
    if (fd == 0) abort_run("cannot open alloc_vectors.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0) continue;
      if (line.getc(0) == "H") begin
        void'($sscanf(line, "H %h %h %h", a, s, n));
        size_mem[a] = s;
        next_mem[a] = n;
        if (first_h) free_list_ptr_i = a;  // first header is the sentinel
        first_h = 1'b0;
      end else if (line.getc(0) == "R") begin
        void'($sscanf(line, "R %h %h %h", a, s, n));
        r_best.push_back(a);
        r_size.push_back(s);
        r_exp.push_back(n);
      end else if (line.getc(0) == "C") begin
        void'($sscanf(line, "C %h %h %h", a, s, n));
        c_addr.push_back(a);
        c_size.push_back(s);
        c_next.push_back(n);
      end
    end
    $fclose(fd);

    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    foreach (r_size[i]) begin
      wait_cnt = 0;
      @(posedge clk_i);
      #1;
      while (!req_ready_o) begin
        if (wait_cnt == TIMEOUT) abort_run("timeout: req_ready_o stayed low");
        wait_cnt++;
        @(posedge clk_i);
        #1;
      end
      req_valid_i    = 1'b1;
      req_size_i     = r_size[i];
      req_strategy_i = r_best[i][0] ? heap_pkg::BEST_FIT : heap_pkg::FIRST_FIT;
      writes_before  = write_count;
      @(posedge clk_i);
      #1;
      req_valid_i = 1'b0;
      wait_cnt    = 0;
      got         = 1'b0;
      while (!got) begin
        res_seed       = lcg_next(res_seed);
        result_ready_i = (res_seed[17:16] != 2'b00);
        if (result_valid_o && result_ready_i) begin
          got = 1'b1;
        end else begin
          if (wait_cnt == TIMEOUT) abort_run("timeout: no result for a request");
          wait_cnt++;
          @(posedge clk_i);
          #1;
        end
      end
      if (result_addr_o != r_exp[i]) begin
        $display("[ERROR] request %0d addr expected %h actual %h", i, r_exp[i], result_addr_o);
        mismatches++;
      end
      // a failed request must not touch memory
      if (r_exp[i] == '0 && write_count != writes_before) begin
        $display("request %0d found no block but wrote %0d headers",
                 i, write_count - writes_before);
        other_errors++;
      end
      @(posedge clk_i);
      #1 result_ready_i = 1'b0;
    end

    foreach (c_addr[i]) begin
      if (!size_mem.exists(c_addr[i])) begin
        $display("header at %h missing from memory", c_addr[i]);
        other_errors++;
      end else begin
        if (size_mem[c_addr[i]] != c_size[i]) begin
          $display("[ERROR] hdr %h size expected %h actual %h",
                   c_addr[i], c_size[i], size_mem[c_addr[i]]);
          mismatches++;
        end
        if (next_mem[c_addr[i]] != c_next[i]) begin
          $display("[ERROR] hdr %h next expected %h actual %h",
                   c_addr[i], c_next[i], next_mem[c_addr[i]]);
          mismatches++;
        end
      end
    end

    $display("done: %0d requests, %0d mismatches, %0d other errors",
             r_size.size(), mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
